// File: Makefile
# Verilator build and run of the object engine testbench
VERILATOR ?= verilator
TOP       ?= obj_tb
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FLIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@! grep -q "Test FAILED" $(LOG)
	@grep -q "Test OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/obj_tb.sv
// --------------------
// table model is combinational, rom answers after 1 to 6 cycles
// --------------------
`timescale 1ns/100ps
`default_nettype none

module obj_tb;

    localparam int NUM_DRAW = 3;
    localparam int SCENES   = 6;
    localparam int LINE_CYC = 256 * 5 + 8 * 4 * 40 + 600;  // scan, draw, sweep
    localparam int LIMIT    = SCENES * 2 * LINE_CYC;       // two lines per scene

    logic        clk;
    logic        rst;
    logic        start;
    logic [7:0]  vrender;
    logic [8:0]  hdump;
    logic [9:0]  table_addr;
    logic [15:0] table_data;
    logic [19:0] rom_addr;
    logic        rom_half;
    logic [31:0] rom_data = '0;
    logic        rom_cs;
    logic        rom_ok   = 1'b0;
    logic [8:0]  pxl;
    logic        done;

    logic [15:0] tbl [1024];        // entry i at words 4i..4i+3
    logic [8:0]  exp_line [512];
    int          tag [512];
    int          seed     = 26;
    int          errors   = 0;
    int          checks   = 0;
    int          cycles   = 0;
    int          rom_wait = 0;
    int          rom_reads = 0;     // rom reads started in this scene
    int          exp_reads = 0;     // rom reads per line, from the reference
    logic        rom_busy = 1'b0;
    logic        chk      = 1'b0;
    logic        chk_q    = 1'b0;
    logic [8:0]  hd_q     = '0;
    logic        rst_chk  = 1'b0;
    logic        end_chk  = 1'b0;
    logic [7:0]  end_idx  = '0;
    string       test_name = "reset";

    obj_top #(.NUM_DRAW(NUM_DRAW)) obj_top_i (
        .clk(clk), .rst(rst), .start(start), .vrender(vrender), .hdump(hdump),
        .table_addr(table_addr), .table_data(table_data),
        .rom_addr(rom_addr), .rom_half(rom_half), .rom_data(rom_data),
        .rom_cs(rom_cs), .rom_ok(rom_ok), .pxl(pxl), .done(done)
    );

    assign table_data = tbl[table_addr];

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // color rule of the rom model, codes with bit 7 set show odd pixels as empty
    function automatic logic [3:0] pix_color(logic [15:0] tile, logic [3:0] line, int p);
        if (tile[7] && (p % 2) == 1) return 4'd15;
        return 4'((int'(tile) + int'(line) + p) % 15);
    endfunction

    function automatic logic [31:0] rom_word(logic [19:0] addr, logic half);
        logic [31:0] w;
        for (int n = 0; n < 8; n++) w[4*n +: 4] = pix_color(addr[19:4], addr[3:0], 8 * half + n);
        return w;
    endfunction

    // rom model with random latency
    always @(posedge clk) begin
        if (rst) begin
            rom_ok   <= 1'b0;
            rom_busy <= 1'b0;
        end else if (rom_ok) begin
            rom_ok   <= 1'b0;
            rom_busy <= 1'b0;
        end else if (rom_cs && !rom_busy) begin
            rom_busy <= 1'b1;
            rom_wait <= 1 + ($unsigned($random(seed)) % 6);
            rom_reads++;
        end else if (rom_busy) begin
            if (rom_wait <= 1) begin
                rom_ok   <= 1'b1;
                rom_data <= rom_word(rom_addr, rom_half);
            end else begin
                rom_wait <= rom_wait - 1;
            end
        end
    end

    // pxl lags hdump by one cycle
    always @(posedge clk) begin
        hd_q  <= hdump;
        chk_q <= chk;
        if (chk_q) begin
            checks++;
            assert (pxl === exp_line[hd_q]) else begin
                errors++;
                $display("FAILED %s x=%0d expected %h actual %h", test_name, hd_q,
                         exp_line[hd_q], pxl);
            end
        end
        if (rst_chk) begin
            checks++;
            assert (rom_cs === 1'b0 && done === 1'b1 && table_addr === 10'h3ff) else begin
                errors++;
                $display("FAILED reset expected rom_cs=0 done=1 addr=3ff actual %b %b %h",
                         rom_cs, done, table_addr);
            end
        end
        if (end_chk && !done) begin
            assert (table_addr >= {end_idx, 2'b00}) else begin
                errors++;
                $display("scan read below the end marker, table_addr %h", table_addr);
            end
        end
    end

    task automatic put_obj(int idx, logic [15:0] attr, logic [15:0] code,
                           logic [15:0] y, logic [15:0] x);
        tbl[4*idx]     = attr;
        tbl[4*idx + 1] = code;
        tbl[4*idx + 2] = y;
        tbl[4*idx + 3] = x;
    endtask

    // filler rows sit 128 lines away, never in zone
    task automatic fill_table(logic [7:0] vr);
        for (int i = 0; i < 256; i++) put_obj(i, 16'd0, 16'd0, {8'd0, vr + 8'd128}, 16'd0);
    endtask

    task automatic build_ref(logic [7:0] vr);
        logic [15:0] a;
        logic [15:0] c;
        logic [15:0] yy;
        logic [15:0] xx;
        logic [7:0]  row;
        logic [3:0]  tn;
        logic [3:0]  tm;
        logic [3:0]  trow;
        logic [3:0]  col_e;
        logic [3:0]  line;
        logic [15:0] tile;
        logic [3:0]  color;
        int          p;
        int          sx;
        exp_reads = 0;
        for (int x = 0; x < 512; x++) begin
            exp_line[x] = '1;
            tag[x]      = 256;
        end
        for (int i = 255; i >= 0; i--) begin
            a  = tbl[4*i];
            c  = tbl[4*i + 1];
            yy = tbl[4*i + 2];
            xx = tbl[4*i + 3];
            if (a == 16'hff00) break;
            if (i < 255 && a == tbl[4*i + 4] && c == tbl[4*i + 5] &&
                yy == tbl[4*i + 6] && xx == tbl[4*i + 7]) continue;
            row = vr - yy[7:0];
            tm  = a[15:12];
            tn  = a[11:8];
            if (int'(row) >= 16 * (int'(tm) + 1)) continue;
            exp_reads += 2 * (int'(tn) + 1);    // two halves per tile column
            for (int cl = 0; cl <= int'(tn); cl++) begin
                col_e = a[5] ? tn - 4'(cl) : 4'(cl);    // whole object mirrored
                trow  = a[6] ? tm - row[7:4] : row[7:4];
                line  = a[6] ? 4'd15 - row[3:0] : row[3:0];
                tile  = 16'(c + 16 * trow + col_e);
                for (int k = 0; k < 16; k++) begin
                    p     = a[5] ? 15 - k : k;
                    color = pix_color(tile, line, p);
                    sx    = (int'(xx[8:0]) + 16 * cl + k) % 512;
                    if (color != 4'd15 && i < tag[sx]) begin
                        tag[sx]      = i;
                        exp_line[sx] = {a[4:0], color};
                    end
                end
            end
        end
    endtask

    task automatic pulse_start();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    // first address goes out on the bank swap edge, each location read once
    task automatic sweep(logic check);
        for (int h = 0; h < 512; h++) begin
            hdump <= 9'(h);
            chk   <= check;
            @(posedge clk);
        end
        chk <= 1'b0;
    endtask

    task automatic wait_done();
        @(posedge clk);
        while (!done) @(posedge clk);
    endtask

    // first line clears the stale bank, second line is checked
    task automatic run_scene(string name, logic [7:0] vr);
        test_name = name;
        vrender  <= vr;
        build_ref(vr);
        rom_reads = 0;
        pulse_start();
        sweep(1'b0);
        wait_done();
        pulse_start();
        sweep(1'b1);
        wait_done();
        checks++;
        assert (rom_reads == 2 * exp_reads) else begin
            errors++;
            $display("FAILED %s rom reads expected %0d actual %0d", name,
                     2 * exp_reads, rom_reads);
        end
    endtask

    initial begin
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, done not seen within %0d cycles", LIMIT);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        rst     = 1'b1;
        start   = 1'b0;
        vrender = '0;
        hdump   = '0;
        fill_table(8'd0);
        repeat (3) @(posedge clk);
        rst     <= 1'b0;
        rst_chk <= 1'b1;
        repeat (4) @(posedge clk);
        rst_chk <= 1'b0;

        fill_table(8'd50);
        put_obj(10, 16'h0003, 16'h0040, 16'd45, 16'd504);     // wraps past 511
        run_scene("single", 8'd50);

        fill_table(8'd60);
        put_obj(20, 16'h1101, 16'h0050, 16'd40, 16'd0);
        put_obj(21, 16'h1122, 16'h0050, 16'd40, 16'd64);      // xflip
        put_obj(22, 16'h1143, 16'h0050, 16'd40, 16'd128);     // yflip
        put_obj(23, 16'h1164, 16'h0050, 16'd40, 16'd192);     // both
        run_scene("flips", 8'd60);

        fill_table(8'd90);
        put_obj(5, 16'h0005, 16'h0080, 16'd85, 16'd100);      // odd pixels empty
        put_obj(6, 16'h0006, 16'h0044, 16'd88, 16'd104);
        put_obj(7, 16'h0007, 16'h0048, 16'd80, 16'd300);
        put_obj(9, 16'h0009, 16'h004c, 16'd82, 16'd296);
        run_scene("priority", 8'd90);

        fill_table(8'd120);
        put_obj(30, 16'h1008, 16'h0060, 16'd89, 16'd40);      // row 31, last row in zone
        put_obj(29, 16'h1008, 16'h0060, 16'd89, 16'd40);      // repeat
        put_obj(28, 16'h1009, 16'h0064, 16'd88, 16'd200);     // row 32, out of zone
        put_obj(25, 16'hff00, 16'h0000, 16'd0, 16'd0);
        put_obj(24, 16'h000a, 16'h0068, 16'd118, 16'd300);    // below the end marker
        end_idx <= 8'd25;
        end_chk <= 1'b1;
        run_scene("skipping", 8'd120);
        end_chk <= 1'b0;

        fill_table(8'd200);
        for (int j = 0; j < 8; j++) begin
            put_obj(40 + j, 16'(((j % 2) << 8) | ((j % 3) << 5) | (j + 10)),
                    16'(16'h0040 + 8 * j), 16'(197 - j), 16'(20 + 40 * j));
        end
        run_scene("backpressure", 8'd200);

        fill_table(8'd10);
        put_obj(3, 16'h000c, 16'h0070, 16'd2, 16'd256);
        run_scene("next line", 8'd10);

        repeat (4) @(posedge clk);
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/obj_line_buf.sv
// --------------------
// every hdump read clears that location, so hdump should sweep once per line
// --------------------
`timescale 1ns/100ps
`default_nettype none

module obj_line_buf #(
    parameter int NUM_DRAW = 3
) (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             start,
    input  wire  [8:0]                      hdump,
    input  wire  [NUM_DRAW-1:0]             wr,
    input  wire  [8:0]                      wr_x [NUM_DRAW],
    input  wire  [obj_pkg::PXL_W-1:0]       wr_pxl [NUM_DRAW],
    input  wire  [obj_pkg::IDX_W-1:0]       wr_idx [NUM_DRAW],
    output logic [obj_pkg::PXL_W-1:0]       pxl
);

    localparam int ENT_W = obj_pkg::IDX_W + obj_pkg::PXL_W;    // {tag, pixel}

    logic [ENT_W-1:0]    mem [2][512];
    logic                sel;           // bank being drawn
    logic [NUM_DRAW-1:0] win;

    // a write lands if opaque, not beaten by the stored tag or a lower index this cycle
    always_comb begin
        for (int k = 0; k < NUM_DRAW; k++) begin
            win[k] = wr[k] && wr_pxl[k][3:0] != obj_pkg::TRANSPARENT &&
                     wr_idx[k] <= mem[sel][wr_x[k]][obj_pkg::PXL_W +: obj_pkg::IDX_W];
            for (int j = 0; j < NUM_DRAW; j++) begin
                if (j != k && wr[j] && wr_x[j] == wr_x[k] &&
                    wr_pxl[j][3:0] != obj_pkg::TRANSPARENT &&
                    (wr_idx[j] < wr_idx[k] || (wr_idx[j] == wr_idx[k] && j < k))) begin
                    win[k] = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel <= 1'b0;
            pxl <= '1;
            for (int b = 0; b < 2; b++) begin
                for (int a = 0; a < 512; a++) begin
                    mem[b][a] <= '1;    // empty, tag all ones
                end
            end
        end else begin
            if (start) sel <= ~sel;
            pxl            <= mem[!sel][hdump][obj_pkg::PXL_W-1:0];
            mem[!sel][hdump] <= '1;     // clear behind the read
            for (int k = 0; k < NUM_DRAW; k++) begin
                if (win[k]) mem[sel][wr_x[k]] <= {wr_idx[k], wr_pxl[k]};
            end
        end
    end

endmodule

`default_nettype wire

// File: design/obj_pkg.sv
// --------------------
// widths and attribute fields shared by the object engine
// table entry i holds attr, code, y, x at word addresses 4i..4i+3
// --------------------
`default_nettype none

package obj_pkg;

    localparam int TABLE_AW = 10;   // 256 entries of 4 words
    localparam int IDX_W    = 8;    // entry index, also the priority tag
    localparam int ROM_AW   = 20;   // {tile code, tile line}
    localparam int PXL_W    = 9;    // {palette, color}

    localparam logic [3:0]  TRANSPARENT = 4'd15;    // never written
    localparam logic [15:0] END_ATTR    = 16'hff00; // stops the scan

    // attribute word fields
    localparam int ATTR_PAL_LO = 0;
    localparam int ATTR_PAL_W  = 5;
    localparam int ATTR_XFLIP  = 5;
    localparam int ATTR_YFLIP  = 6;
    localparam int ATTR_TN_LO  = 8;     // extra tile columns
    localparam int ATTR_TN_W   = 4;
    localparam int ATTR_TM_LO  = 12;    // extra tile rows
    localparam int ATTR_TM_W   = 4;

endpackage

`default_nettype wire

// File: design/obj_rom_arb.sv
// --------------------
// a requester must drop req while its ack is high
// --------------------
`timescale 1ns/100ps
`default_nettype none

module obj_rom_arb #(
    parameter int NUM_DRAW = 3
) (
    input  wire                             clk,
    input  wire                             rst,
    input  wire  [NUM_DRAW-1:0]             req,
    input  wire  [obj_pkg::ROM_AW-1:0]      req_addr [NUM_DRAW],
    input  wire  [NUM_DRAW-1:0]             req_half,
    input  wire  [31:0]                     rom_data,
    input  wire                             rom_ok,
    output logic [NUM_DRAW-1:0]             ack,
    output logic [31:0]                     ack_data,
    output logic [obj_pkg::ROM_AW-1:0]      rom_addr,
    output logic                            rom_half,
    output logic                            rom_cs
);

    localparam int GW = (NUM_DRAW > 1) ? $clog2(NUM_DRAW) : 1;

    logic [GW-1:0] ptr;     // first unit to look at
    logic [GW-1:0] gnt;     // unit being served
    logic [GW-1:0] sel;
    logic          found;

    always_comb begin
        found = 1'b0;
        sel   = '0;
        for (int i = 0; i < NUM_DRAW; i++) begin
            if (!found && req[(int'(ptr) + i) % NUM_DRAW]) begin
                found = 1'b1;
                sel   = GW'((int'(ptr) + i) % NUM_DRAW);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_cs <= 1'b0;
            ack    <= '0;
            ptr    <= '0;
            gnt    <= '0;
        end else begin
            ack <= '0;
            if (!rom_cs) begin
                if (found) begin
                    rom_cs <= 1'b1;
                    gnt    <= sel;
                    ptr    <= (sel == GW'(NUM_DRAW - 1)) ? '0 : sel + 1'b1;
                end
            end else if (rom_ok) begin
                rom_cs   <= 1'b0;   // at least one idle cycle between reads
                ack[gnt] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rom_cs && found) begin
            rom_addr <= req_addr[sel];
            rom_half <= req_half[sel];
        end
        if (rom_cs && rom_ok) ack_data <= rom_data;
    end

endmodule

`default_nettype wire

// File: design/obj_scan.sv
// --------------------
// vrender must stay stable for the whole scan
// start must only come while done is high
// --------------------
`timescale 1ns/100ps
`default_nettype none

module obj_scan #(
    parameter int NUM_DRAW = 3
) (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             start,
    input  wire  [7:0]                      vrender,
    input  wire  [15:0]                     table_data,
    input  wire  [NUM_DRAW-1:0]             idle,
    output logic [obj_pkg::TABLE_AW-1:0]    table_addr,
    output logic [NUM_DRAW-1:0]             load,
    output logic [15:0]                     ld_attr,
    output logic [15:0]                     ld_code,
    output logic [8:0]                      ld_x,
    output logic [7:0]                      ld_row,
    output logic [obj_pkg::IDX_W-1:0]       ld_idx,
    output logic                            done
);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_READ  = 2'd1;
    localparam logic [1:0] S_CHECK = 2'd2;

    logic [1:0]                 st;
    logic                       ended;      // scan over, units may still draw
    logic                       prv_vld;    // previous entry held for this line
    logic [15:0]                cur_attr;
    logic [15:0]                cur_code;
    logic [15:0]                cur_y;
    logic [15:0]                cur_x;
    logic [obj_pkg::IDX_W-1:0]  cur_idx;
    logic [15:0]                prv_attr;
    logic [15:0]                prv_code;
    logic [15:0]                prv_y;
    logic [15:0]                prv_x;
    logic [7:0]                 row;
    logic [8:0]                 zone_h;
    logic                       repeated;
    logic                       visible;
    logic                       adv;
    logic [NUM_DRAW-1:0]        pick;

    assign row      = vrender - cur_y[7:0];  // object relative, mod 256
    assign zone_h   = {1'b0, cur_attr[obj_pkg::ATTR_TM_LO +: obj_pkg::ATTR_TM_W], 4'd0} + 9'd16;
    assign repeated = prv_vld && cur_attr == prv_attr && cur_code == prv_code &&
                      cur_y == prv_y && cur_x == prv_x;
    assign visible  = !repeated && ({1'b0, row} < zone_h);
    assign pick     = idle & (~idle + 1'b1);    // lowest idle unit
    assign adv      = (st == S_CHECK) && (!visible || (|idle));

    assign load    = (st == S_CHECK && visible) ? pick : '0;
    assign ld_attr = cur_attr;
    assign ld_code = cur_code;
    assign ld_x    = cur_x[8:0];
    assign ld_row  = row;
    assign ld_idx  = cur_idx;
    assign done    = ended & (&idle);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st         <= S_IDLE;
            table_addr <= '1;
            ended      <= 1'b1;
            prv_vld    <= 1'b0;
        end else begin
            case (st)
                S_IDLE: if (start) begin
                    st      <= S_READ;
                    ended   <= 1'b0;
                    prv_vld <= 1'b0;
                end
                S_READ: begin
                    if (table_addr[1:0] == 2'd0 && table_data == obj_pkg::END_ATTR) begin
                        table_addr <= '1;       // end marker, rewind for next line
                        ended      <= 1'b1;
                        st         <= S_IDLE;
                    end else begin
                        table_addr <= table_addr - 1'b1;    // wraps to all ones after entry 0
                        if (table_addr[1:0] == 2'd0) st <= S_CHECK;
                    end
                end
                S_CHECK: if (adv) begin
                    prv_vld <= 1'b1;
                    if (cur_idx == '0) begin
                        ended <= 1'b1;
                        st    <= S_IDLE;
                    end else begin
                        st <= S_READ;
                    end
                end
                default: st <= S_IDLE;
            endcase
        end
    end

    // entry words arrive x first, attr last
    always_ff @(posedge clk) begin
        if (st == S_READ) begin
            case (table_addr[1:0])
                2'd3: cur_x    <= table_data;
                2'd2: cur_y    <= table_data;
                2'd1: cur_code <= table_data;
                default: begin
                    cur_attr <= table_data;
                    cur_idx  <= table_addr[obj_pkg::TABLE_AW-1:2];
                end
            endcase
        end
        if (adv) begin
            prv_attr <= cur_attr;   // skipped entries count as previous too
            prv_code <= cur_code;
            prv_y    <= cur_y;
            prv_x    <= cur_x;
        end
    end

endmodule

`default_nettype wire

// File: design/obj_tile_draw.sv
// --------------------
// rom half 0 holds pixels 0..7, half 1 pixels 8..15, pixel p in nibble p mod 8
// --------------------
`timescale 1ns/100ps
`default_nettype none

module obj_tile_draw (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             load,
    input  wire  [15:0]                     ld_attr,
    input  wire  [15:0]                     ld_code,
    input  wire  [8:0]                      ld_x,
    input  wire  [7:0]                      ld_row,
    input  wire  [obj_pkg::IDX_W-1:0]       ld_idx,
    input  wire                             ack,
    input  wire  [31:0]                     ack_data,
    output logic                            idle,
    output logic                            req,
    output logic [obj_pkg::ROM_AW-1:0]      req_addr,
    output logic                            req_half,
    output logic                            wr,
    output logic [8:0]                      wr_x,
    output logic [obj_pkg::PXL_W-1:0]       wr_pxl,
    output logic [obj_pkg::IDX_W-1:0]       wr_idx
);

    localparam logic [1:0] D_IDLE  = 2'd0;
    localparam logic [1:0] D_FETCH = 2'd1;
    localparam logic [1:0] D_DRAW  = 2'd2;

    logic [1:0]                         st;
    logic [15:0]                        attr_r;
    logic [15:0]                        code_r;
    logic [7:0]                         row_r;
    logic [8:0]                         px;         // next screen x
    logic [3:0]                         col;        // screen order column
    logic [3:0]                         cnt;
    logic                               half;
    logic [63:0]                        sh;         // one tile row, 16 nibbles
    logic [3:0]                         tn;
    logic [3:0]                         tm;
    logic                               xflip;
    logic                               yflip;
    logic [obj_pkg::ATTR_PAL_W-1:0]     pal;
    logic [3:0]                         col_eff;
    logic [3:0]                         trow_eff;
    logic [3:0]                         line;
    logic [15:0]                        tile;

    assign tn    = attr_r[obj_pkg::ATTR_TN_LO +: obj_pkg::ATTR_TN_W];
    assign tm    = attr_r[obj_pkg::ATTR_TM_LO +: obj_pkg::ATTR_TM_W];
    assign xflip = attr_r[obj_pkg::ATTR_XFLIP];
    assign yflip = attr_r[obj_pkg::ATTR_YFLIP];
    assign pal   = attr_r[obj_pkg::ATTR_PAL_LO +: obj_pkg::ATTR_PAL_W];

    // flips mirror the whole object, not each tile
    assign col_eff  = xflip ? tn - col : col;
    assign trow_eff = yflip ? tm - row_r[7:4] : row_r[7:4];
    assign line     = yflip ? ~row_r[3:0] : row_r[3:0];
    assign tile     = code_r + {8'd0, trow_eff, 4'd0} + {12'd0, col_eff};

    assign idle     = (st == D_IDLE);
    assign req      = (st == D_FETCH) && !ack;  // off at once so the arbiter skips us
    assign req_addr = {tile, line};
    assign req_half = half;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st   <= D_IDLE;
            col  <= '0;
            cnt  <= '0;
            half <= 1'b0;
            wr   <= 1'b0;
        end else begin
            wr <= (st == D_DRAW);
            case (st)
                D_IDLE: if (load) begin
                    st   <= D_FETCH;
                    col  <= '0;
                    half <= 1'b0;
                end
                D_FETCH: if (ack) begin
                    half <= ~half;
                    if (half) begin
                        st  <= D_DRAW;  // both halves in
                        cnt <= '0;
                    end
                end
                D_DRAW: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == 4'd15) begin
                        if (col == tn) begin
                            st <= D_IDLE;
                        end else begin
                            col <= col + 1'b1;
                            st  <= D_FETCH;
                        end
                    end
                end
                default: st <= D_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load && idle) begin
            attr_r <= ld_attr;
            code_r <= ld_code;
            row_r  <= ld_row;
            px     <= ld_x;
            wr_idx <= ld_idx;
        end
        if (st == D_FETCH && ack) sh <= half ? {ack_data, sh[31:0]} : {sh[63:32], ack_data};
        if (st == D_DRAW) begin
            sh     <= xflip ? sh << 4 : sh >> 4;
            wr_x   <= px;
            px     <= px + 1'b1;                // wraps at 512
            wr_pxl <= {pal, xflip ? sh[63:60] : sh[3:0]};
        end
    end

endmodule

`default_nettype wire

// File: design/obj_top.sv
// --------------------
// table and rom live outside, pxl lags hdump by one cycle
// --------------------
`timescale 1ns/100ps
`default_nettype none

module obj_top #(
    parameter int NUM_DRAW = 3     // 1 to 8
) (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             start,
    input  wire  [7:0]                      vrender,
    input  wire  [8:0]                      hdump,
    output logic [obj_pkg::TABLE_AW-1:0]    table_addr,
    input  wire  [15:0]                     table_data,
    output logic [obj_pkg::ROM_AW-1:0]      rom_addr,
    output logic                            rom_half,
    input  wire  [31:0]                     rom_data,
    output logic                            rom_cs,
    input  wire                             rom_ok,
    output logic [obj_pkg::PXL_W-1:0]       pxl,
    output logic                            done
);

    logic [NUM_DRAW-1:0]            load;
    logic [NUM_DRAW-1:0]            idle;
    logic [15:0]                    ld_attr;
    logic [15:0]                    ld_code;
    logic [8:0]                     ld_x;
    logic [7:0]                     ld_row;
    logic [obj_pkg::IDX_W-1:0]      ld_idx;
    logic [NUM_DRAW-1:0]            req;
    logic [obj_pkg::ROM_AW-1:0]     req_addr [NUM_DRAW];
    logic [NUM_DRAW-1:0]            req_half;
    logic [NUM_DRAW-1:0]            ack;
    logic [31:0]                    ack_data;
    logic [NUM_DRAW-1:0]            wr;
    logic [8:0]                     wr_x [NUM_DRAW];
    logic [obj_pkg::PXL_W-1:0]      wr_pxl [NUM_DRAW];
    logic [obj_pkg::IDX_W-1:0]      wr_idx [NUM_DRAW];

    obj_scan #(.NUM_DRAW(NUM_DRAW)) obj_scan_i (
        .clk(clk), .rst(rst), .start(start), .vrender(vrender),
        .table_data(table_data), .idle(idle), .table_addr(table_addr),
        .load(load), .ld_attr(ld_attr), .ld_code(ld_code), .ld_x(ld_x),
        .ld_row(ld_row), .ld_idx(ld_idx), .done(done)
    );

    for (genvar k = 0; k < NUM_DRAW; k++) begin : g_draw
        obj_tile_draw obj_tile_draw_i (
            .clk(clk), .rst(rst), .load(load[k]),
            .ld_attr(ld_attr), .ld_code(ld_code), .ld_x(ld_x),
            .ld_row(ld_row), .ld_idx(ld_idx),
            .ack(ack[k]), .ack_data(ack_data),
            .idle(idle[k]), .req(req[k]), .req_addr(req_addr[k]),
            .req_half(req_half[k]), .wr(wr[k]), .wr_x(wr_x[k]),
            .wr_pxl(wr_pxl[k]), .wr_idx(wr_idx[k])
        );
    end

    obj_rom_arb #(.NUM_DRAW(NUM_DRAW)) obj_rom_arb_i (
        .clk(clk), .rst(rst), .req(req), .req_addr(req_addr),
        .req_half(req_half), .rom_data(rom_data), .rom_ok(rom_ok),
        .ack(ack), .ack_data(ack_data), .rom_addr(rom_addr),
        .rom_half(rom_half), .rom_cs(rom_cs)
    );

    obj_line_buf #(.NUM_DRAW(NUM_DRAW)) obj_line_buf_i (
        .clk(clk), .rst(rst), .start(start), .hdump(hdump),
        .wr(wr), .wr_x(wr_x), .wr_pxl(wr_pxl), .wr_idx(wr_idx),
        .pxl(pxl)
    );

endmodule

`default_nettype wire

// File: vlog.f
design/obj_pkg.sv
design/obj_scan.sv
design/obj_tile_draw.sv
design/obj_rom_arb.sv
design/obj_line_buf.sv
design/obj_top.sv
bench/obj_tb.sv
